/* hdl/ddr3_params.svh */
`ifndef DDR3_PARAMS_SVH
`define DDR3_PARAMS_SVH

// Address and data path widths
`define DDR_ROW_BITS 13
`define DDR_BANK_BITS 3
`define DFI_DATA_BITS 32
`define DFI_MASK_BITS 4

// CAS write latency and CAS latency, in controller clock cycles
`define DDR_CWL 6
`define DDR_CL 6

// Register stages inside the PHY on the data paths
`define PHY_WR_LATENCY 1
`define PHY_RD_LATENCY 1

// BL8 takes four clock cycles at double data rate
`define BURST_CYCLES 4

// Command timing, in cycles that ctl_rdy_o stays low after acceptance

// Wait from clock enable to the first command
`define T_INIT 5
// Activate to read or write
`define T_RCD 3
// Precharge to activate
`define T_RP 2
// Refresh cycle time
`define T_RFC 11
// Mode register set to next command
`define T_MRD 4
// Read to read, write to write
`define T_CCD 4
// Read to write turnaround
`define T_RTW 6
// Write to read turnaround, includes write recovery
`define T_WTR 18
// Read and write with auto-precharge, until the bank is idle again
`define T_RDA 12
`define T_WRA 14
// Initial ZQ calibration
`define T_ZQINIT 512

// Wide enough for T_ZQINIT
`define TIMER_BITS 10

`endif

/* hdl/ddr3_cmd_pkg.sv */
`default_nettype none

`include "ddr3_params.svh"

package ddr3_cmd_pkg;

  // RAS_n, CAS_n, WE_n as seen on the DDR3 pins
  typedef enum logic [2:0] {
    CMD_MRS  = 3'b000,
    CMD_REF  = 3'b001,
    CMD_PRE  = 3'b010,
    CMD_ACT  = 3'b011,
    CMD_WR   = 3'b100,
    CMD_RD   = 3'b101,
    CMD_ZQCL = 3'b110,
    CMD_NOP  = 3'b111
  } ddr_cmd_e;

  // ST_INIT covers the wait after reset or clock enable
  typedef enum logic [3:0] {
    ST_INIT,
    ST_IDLE,
    ST_ACTV,
    ST_READ,
    ST_WRIT,
    ST_PREC,
    ST_REFR,
    ST_MODE,
    ST_ZQCL
  } ddr_state_e;

  typedef logic [`DDR_ROW_BITS-1:0] row_addr_t;
  typedef logic [`DDR_BANK_BITS-1:0] bank_t;

  typedef struct packed {
    ddr_cmd_e  cmd;
    bank_t     bank;
    row_addr_t addr;
  } dfi_cmd_t;

  typedef logic [`TIMER_BITS-1:0] delay_t;

endpackage

`default_nettype wire

/* hdl/ddr3_data_pkg.sv */
`default_nettype none

`include "ddr3_params.svh"

package ddr3_data_pkg;

  // One DFI data word, half of the BL8 burst beat pair per clock
  typedef logic [`DFI_DATA_BITS-1:0] dfi_data_t;

  // Byte mask, high masks the byte
  typedef logic [`DFI_MASK_BITS-1:0] dfi_mask_t;

  typedef struct packed {
    dfi_mask_t mask;
    dfi_data_t data;
  } wr_beat_t;

endpackage

`default_nettype wire

/* hdl/ddr3_delay_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_params.svh"

module ddr3_delay_timer (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   load_i,
  input  ddr3_cmd_pkg::delay_t  delay_i,
  output logic                  expired_o
);

  import ddr3_cmd_pkg::*;

  delay_t count;

  // Reset starts the init wait, so the first ready comes T_INIT cycles later
  always_ff @(posedge clock) begin
    if (reset) begin
      count <= delay_t'(`T_INIT);
    end else if (load_i) begin
      count <= delay_i;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign expired_o = (count == '0);

  // Commands are only accepted once the previous delay has run out
  a_no_early_load : assert property (@(posedge clock) disable iff (reset)
    load_i |-> expired_o)
    else $error("timer loaded with %0d cycles still to run", count);

endmodule

`default_nettype wire

/* hdl/ddr3_burst_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_params.svh"

// LATENCY counts from the issue cycle to the first enabled cycle, at least 2
module ddr3_burst_path #(
  parameter int LATENCY = 5
) (
  input  wire   clock,
  input  wire   reset,
  input  wire   issue_i,
  output logic  lead_o,
  output logic  enable_o
);

  localparam int DEPTH = LATENCY - 1;
  localparam int CBITS = $clog2(`BURST_CYCLES + 1);

  logic [DEPTH-1:0] line;
  logic [CBITS-1:0] count;
  logic             reload;

  // Issue pulses travel down the line, several may be in flight
  always_ff @(posedge clock) begin
    if (reset) begin
      line <= '0;
    end else begin
      line <= (line << 1) | DEPTH'(issue_i);
    end
  end

  // A pulse leaving the line opens the window on the next cycle
  assign reload = line[DEPTH-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else if (reload) begin
      count <= CBITS'(`BURST_CYCLES);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign enable_o = (count != '0);

  // Window shifted one cycle early, stays unbroken across reloads
  assign lead_o = reload | (count > CBITS'(1));

  a_window_len : assert property (@(posedge clock) disable iff (reset)
    reload ##1 (!reload)[*`BURST_CYCLES] |=> !enable_o)
    else $error("burst window longer than %0d cycles", `BURST_CYCLES);

endmodule

`default_nettype wire

/* hdl/ddr3_cmd_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_params.svh"

module ddr3_cmd_fsm (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       cke_i,
  input  wire                       ctl_req_i,
  input  ddr3_cmd_pkg::dfi_cmd_t    ctl_cmd_i,
  output logic                      ctl_rdy_o,
  output logic                      ctl_run_o,
  output ddr3_cmd_pkg::dfi_cmd_t    dfi_cmd_o,
  output logic                      load_o,
  output ddr3_cmd_pkg::delay_t      delay_o,
  input  wire                       expired_i,
  output logic                      write_issue_o,
  output logic                      read_issue_o
);

  import ddr3_cmd_pkg::*;

  ddr_state_e state;
  ddr_state_e state_nxt;
  delay_t     delay_nxt;
  logic       hold;
  logic       accept;
  logic       auto_pre;
  logic       cmd_legal;
  logic       run_q;
  ddr_cmd_e   cmd_q;
  bank_t      bank_q;
  row_addr_t  addr_q;

  // Clock enable low keeps the whole layer in reset
  assign hold = reset | ~cke_i;

  // Ready whenever the timer has run out
  assign ctl_rdy_o = expired_i;
  assign accept    = ctl_req_i & expired_i;
  assign auto_pre  = ctl_cmd_i.addr[10];

  // Run rises together with the first ready
  assign ctl_run_o = run_q | expired_i;

  assign load_o  = accept;
  assign delay_o = delay_nxt;

  // Delay and next state for the requested command
  always_comb begin
    state_nxt = ST_IDLE;
    delay_nxt = '0;
    case (ctl_cmd_i.cmd)
      CMD_ACT: begin
        state_nxt = ST_ACTV;
        delay_nxt = delay_t'(`T_RCD);
      end
      CMD_RD: begin
        if (auto_pre) begin
          delay_nxt = delay_t'(`T_RDA);
        end else begin
          state_nxt = ST_READ;
          delay_nxt = (state == ST_WRIT) ? delay_t'(`T_WTR) : delay_t'(`T_CCD);
        end
      end
      CMD_WR: begin
        if (auto_pre) begin
          delay_nxt = delay_t'(`T_WRA);
        end else begin
          state_nxt = ST_WRIT;
          delay_nxt = (state == ST_READ) ? delay_t'(`T_RTW) : delay_t'(`T_CCD);
        end
      end
      CMD_PRE: begin
        state_nxt = ST_PREC;
        delay_nxt = delay_t'(`T_RP);
      end
      CMD_REF: begin
        state_nxt = ST_REFR;
        delay_nxt = delay_t'(`T_RFC);
      end
      CMD_MRS: begin
        state_nxt = ST_MODE;
        delay_nxt = delay_t'(`T_MRD);
      end
      CMD_ZQCL: begin
        state_nxt = ST_ZQCL;
        delay_nxt = delay_t'(`T_ZQINIT);
      end
      default: begin
        // NOP leaves the memory idle with no wait
        state_nxt = ST_IDLE;
      end
    endcase
  end

  // A command accepted at the end of the init wait is checked as from IDLE
  always_comb begin
    case (state)
      ST_INIT, ST_IDLE: begin
        cmd_legal = ctl_cmd_i.cmd inside {CMD_ACT, CMD_PRE, CMD_REF, CMD_MRS,
                                          CMD_ZQCL, CMD_NOP};
      end
      ST_ACTV, ST_READ, ST_WRIT: cmd_legal = ctl_cmd_i.cmd inside {CMD_RD, CMD_WR, CMD_ACT};
      ST_PREC: cmd_legal = ctl_cmd_i.cmd inside {CMD_ACT, CMD_REF, CMD_NOP};
      ST_REFR: cmd_legal = ctl_cmd_i.cmd inside {CMD_ACT, CMD_REF};
      ST_MODE: cmd_legal = ctl_cmd_i.cmd inside {CMD_MRS, CMD_REF, CMD_PRE, CMD_ZQCL};
      ST_ZQCL: cmd_legal = ctl_cmd_i.cmd inside {CMD_ACT, CMD_REF, CMD_PRE};
      default: cmd_legal = 1'b0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (hold) begin
      state <= ST_INIT;
      run_q <= 1'b0;
      cmd_q <= CMD_NOP;
    end else begin
      cmd_q <= accept ? ctl_cmd_i.cmd : CMD_NOP;
      if (expired_i) begin
        run_q <= 1'b1;
        // No follow-up request means the memory is idle
        state <= ctl_req_i ? state_nxt : ST_IDLE;
      end
    end
  end

  // Bank and address only matter alongside a valid command
  always_ff @(posedge clock) begin
    if (accept) begin
      bank_q <= ctl_cmd_i.bank;
      addr_q <= ctl_cmd_i.addr;
    end
  end

  assign dfi_cmd_o = '{cmd: cmd_q, bank: bank_q, addr: addr_q};

  // Burst windows start from the cycle the command is on the PHY
  assign write_issue_o = (cmd_q == CMD_WR);
  assign read_issue_o  = (cmd_q == CMD_RD);

  // The controller must only send commands allowed by the memory state
  a_cmd_legal : assert property (@(posedge clock) disable iff (hold)
    accept |-> cmd_legal)
    else $error("illegal command %0h in state %s", ctl_cmd_i.cmd, state.name());

endmodule

`default_nettype wire

/* hdl/ddr3_ddl_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_params.svh"

module ddr3_ddl_top (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       ddr_cke_i,

  // Controller command port
  input  wire                       ctl_req_i,
  input  ddr3_cmd_pkg::dfi_cmd_t    ctl_cmd_i,
  output logic                      ctl_rdy_o,
  output logic                      ctl_run_o,

  // Write and read data from and to the controller
  input  ddr3_data_pkg::wr_beat_t   mem_wbeat_i,
  output logic                      mem_wready_o,
  input  wire                       mem_rready_i,
  output logic                      mem_rvalid_o,
  output ddr3_data_pkg::dfi_data_t  mem_rdata_o,

  // PHY side
  output ddr3_cmd_pkg::dfi_cmd_t    dfi_cmd_o,
  output logic                      dfi_wstb_o,
  output logic                      dfi_wren_o,
  output ddr3_data_pkg::wr_beat_t   dfi_wbeat_o,
  output logic                      dfi_rden_o,
  input  wire                       dfi_rvalid_i,
  input  ddr3_data_pkg::dfi_data_t  dfi_rdata_i
);

  import ddr3_cmd_pkg::*;

  logic   ddl_reset;
  logic   load;
  delay_t delay;
  logic   expired;
  logic   write_issue;
  logic   read_issue;

  // Timer and data paths restart whenever clock enable drops
  assign ddl_reset = reset | ~ddr_cke_i;

  ddr3_cmd_fsm u_cmd_fsm (
    .clock         (clock),
    .reset         (reset),
    .cke_i         (ddr_cke_i),
    .ctl_req_i     (ctl_req_i),
    .ctl_cmd_i     (ctl_cmd_i),
    .ctl_rdy_o     (ctl_rdy_o),
    .ctl_run_o     (ctl_run_o),
    .dfi_cmd_o     (dfi_cmd_o),
    .load_o        (load),
    .delay_o       (delay),
    .expired_i     (expired),
    .write_issue_o (write_issue),
    .read_issue_o  (read_issue)
  );

  ddr3_delay_timer u_delay_timer (
    .clock     (clock),
    .reset     (ddl_reset),
    .load_i    (load),
    .delay_i   (delay),
    .expired_o (expired)
  );

  ddr3_burst_path #(
    .LATENCY (`DDR_CWL - `PHY_WR_LATENCY)
  ) wr_path (
    .clock    (clock),
    .reset    (ddl_reset),
    .issue_i  (write_issue),
    .lead_o   (dfi_wstb_o),
    .enable_o (dfi_wren_o)
  );

  // Read strobe comes from the PHY, so no lead is needed here
  ddr3_burst_path #(
    .LATENCY (`DDR_CL - `PHY_RD_LATENCY)
  ) rd_path (
    .clock    (clock),
    .reset    (ddl_reset),
    .issue_i  (read_issue),
    .lead_o   (),
    .enable_o (dfi_rden_o)
  );

  // Data goes straight through, the controller does the buffering
  assign mem_wready_o = dfi_wren_o;
  assign dfi_wbeat_o  = mem_wbeat_i;
  assign mem_rvalid_o = dfi_rvalid_i;
  assign mem_rdata_o  = dfi_rdata_i;

  // Read data cannot be stalled, the controller has to take every beat
  a_no_read_stall : assert property (@(posedge clock) disable iff (ddl_reset)
    mem_rvalid_o |-> mem_rready_i)
    else $error("read data dropped, controller not ready");

endmodule

`default_nettype wire

/* verif/ddr3_ddl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr3_params.svh"

module ddr3_ddl_tb;

  import ddr3_cmd_pkg::*;
  import ddr3_data_pkg::*;

  localparam int WR_LAT = `DDR_CWL - `PHY_WR_LATENCY;
  localparam int RD_LAT = `DDR_CL - `PHY_RD_LATENCY;
  // About 800 cycles are needed, most of them in the ZQ calibration wait
  localparam int CYCLE_LIMIT = 3000;

  logic      clock = 1'b0;
  logic      reset;
  logic      ddr_cke_i;
  logic      ctl_req_i;
  dfi_cmd_t  ctl_cmd_i;
  logic      ctl_rdy_o;
  logic      ctl_run_o;
  wr_beat_t  mem_wbeat_i;
  logic      mem_wready_o;
  logic      mem_rready_i;
  logic      mem_rvalid_o;
  dfi_data_t mem_rdata_o;
  dfi_cmd_t  dfi_cmd_o;
  logic      dfi_wstb_o;
  logic      dfi_wren_o;
  wr_beat_t  dfi_wbeat_o;
  logic      dfi_rden_o;
  logic      dfi_rvalid_i;
  dfi_data_t dfi_rdata_i;

  // Reference model of the command timing and burst windows
  logic        m_hold;
  int          m_wait;
  logic        m_rdy;
  logic        m_accept;
  logic        m_started;
  ddr_state_e  m_state;
  dfi_cmd_t    exp_cmd;
  logic [15:0] wr_hist;
  logic [15:0] rd_hist;
  logic        exp_wren;
  logic        exp_wstb;
  logic        exp_rden;

  logic checks_on = 1'b0;
  int   error_count = 0;
  int   sent_count = 0;
  int   cycle_count = 0;

  ddr3_ddl_top UUT (.*);

  always #10 clock = ~clock;

  function automatic int cmd_delay(ddr_state_e st, dfi_cmd_t c);
    case (c.cmd)
      CMD_ACT:  return `T_RCD;
      CMD_PRE:  return `T_RP;
      CMD_REF:  return `T_RFC;
      CMD_MRS:  return `T_MRD;
      CMD_ZQCL: return `T_ZQINIT;
      CMD_RD: begin
        if (c.addr[10]) return `T_RDA;
        return (st == ST_WRIT) ? `T_WTR : `T_CCD;
      end
      CMD_WR: begin
        if (c.addr[10]) return `T_WRA;
        return (st == ST_READ) ? `T_RTW : `T_CCD;
      end
      default:  return 0;
    endcase
  endfunction

  function automatic ddr_state_e state_after(dfi_cmd_t c);
    case (c.cmd)
      CMD_ACT:  return ST_ACTV;
      CMD_RD:   return c.addr[10] ? ST_IDLE : ST_READ;
      CMD_WR:   return c.addr[10] ? ST_IDLE : ST_WRIT;
      CMD_PRE:  return ST_PREC;
      CMD_REF:  return ST_REFR;
      CMD_MRS:  return ST_MODE;
      CMD_ZQCL: return ST_ZQCL;
      default:  return ST_IDLE;
    endcase
  endfunction

  assign m_hold   = reset | ~ddr_cke_i;
  assign m_rdy    = (m_wait == 0);
  assign m_accept = ctl_req_i & m_rdy;

  // Window of four cycles starting at the latency after the command cycle
  assign exp_wren = |wr_hist[WR_LAT+`BURST_CYCLES-2:WR_LAT-1];
  assign exp_wstb = |wr_hist[WR_LAT+`BURST_CYCLES-3:WR_LAT-2];
  assign exp_rden = |rd_hist[RD_LAT+`BURST_CYCLES-2:RD_LAT-1];

  always @(posedge clock) begin
    if (m_hold) begin
      m_wait      <= `T_INIT;
      m_started   <= 1'b0;
      m_state     <= ST_INIT;
      exp_cmd.cmd <= CMD_NOP;
      wr_hist     <= '0;
      rd_hist     <= '0;
    end else begin
      wr_hist <= {wr_hist[14:0], exp_cmd.cmd == CMD_WR};
      rd_hist <= {rd_hist[14:0], exp_cmd.cmd == CMD_RD};
      if (m_accept) begin
        m_wait  <= cmd_delay(m_state, ctl_cmd_i);
        exp_cmd <= ctl_cmd_i;
      end else begin
        if (m_wait > 0) m_wait <= m_wait - 1;
        exp_cmd.cmd <= CMD_NOP;
      end
      if (m_rdy) begin
        m_started <= 1'b1;
        m_state   <= ctl_req_i ? state_after(ctl_cmd_i) : ST_IDLE;
      end
    end
  end

  always @(posedge clock) begin
    if (reset) checks_on <= 1'b1;
  end

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    error_count = error_count + 1;
    $display("Fail %s at %0t: expected %0h, got %0h", name, $time, expected, actual);
  endtask

  a_rdy : assert property (@(posedge clock) disable iff (!checks_on) ctl_rdy_o == m_rdy)
    else report_mismatch("ctl_rdy_o", $sampled(m_rdy), $sampled(ctl_rdy_o));
  a_run : assert property (@(posedge clock) disable iff (!checks_on)
    ctl_run_o == (m_started | m_rdy))
    else report_mismatch("ctl_run_o", $sampled(m_started | m_rdy), $sampled(ctl_run_o));
  a_cmd : assert property (@(posedge clock) disable iff (!checks_on)
    dfi_cmd_o.cmd == exp_cmd.cmd)
    else report_mismatch("dfi_cmd_o.cmd", $sampled(exp_cmd.cmd), $sampled(dfi_cmd_o.cmd));
  a_cmd_addr : assert property (@(posedge clock) disable iff (!checks_on)
    (exp_cmd.cmd != CMD_NOP) |-> (dfi_cmd_o == exp_cmd))
    else report_mismatch("dfi_cmd_o", $sampled(exp_cmd), $sampled(dfi_cmd_o));
  a_wren : assert property (@(posedge clock) disable iff (!checks_on) dfi_wren_o == exp_wren)
    else report_mismatch("dfi_wren_o", $sampled(exp_wren), $sampled(dfi_wren_o));
  a_wstb : assert property (@(posedge clock) disable iff (!checks_on) dfi_wstb_o == exp_wstb)
    else report_mismatch("dfi_wstb_o", $sampled(exp_wstb), $sampled(dfi_wstb_o));
  a_rden : assert property (@(posedge clock) disable iff (!checks_on) dfi_rden_o == exp_rden)
    else report_mismatch("dfi_rden_o", $sampled(exp_rden), $sampled(dfi_rden_o));
  a_wready : assert property (@(posedge clock) disable iff (!checks_on)
    mem_wready_o == exp_wren)
    else report_mismatch("mem_wready_o", $sampled(exp_wren), $sampled(mem_wready_o));
  a_wbeat : assert property (@(posedge clock) dfi_wbeat_o == mem_wbeat_i)
    else report_mismatch("dfi_wbeat_o", $sampled(mem_wbeat_i), $sampled(dfi_wbeat_o));
  a_rvalid : assert property (@(posedge clock) mem_rvalid_o == dfi_rvalid_i)
    else report_mismatch("mem_rvalid_o", $sampled(dfi_rvalid_i), $sampled(mem_rvalid_o));
  a_rdata : assert property (@(posedge clock) mem_rdata_o == dfi_rdata_i)
    else report_mismatch("mem_rdata_o", $sampled(dfi_rdata_i), $sampled(mem_rdata_o));

  // Random data on both data paths, read data always taken
  always @(negedge clock) begin
    mem_wbeat_i  = wr_beat_t'({$urandom, $urandom});
    dfi_rvalid_i = 1'($urandom);
    dfi_rdata_i  = dfi_data_t'($urandom);
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT) begin
      $display("Timeout, the command sequences did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Run finished: %0d commands sent, %0d errors", sent_count, error_count);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic dfi_cmd_t random_cmd(ddr_cmd_e cmd, logic auto_pre);
    dfi_cmd_t c;
    c.cmd      = cmd;
    c.bank     = bank_t'($urandom);
    c.addr     = row_addr_t'($urandom);
    c.addr[10] = auto_pre;
    return c;
  endfunction

  // Called on a falling edge, returns on the falling edge after acceptance
  task automatic send(input ddr_cmd_e cmd, input logic auto_pre);
    ctl_req_i = 1'b1;
    ctl_cmd_i = random_cmd(cmd, auto_pre);
    while (!ctl_rdy_o) @(negedge clock);
    @(negedge clock);
    sent_count = sent_count + 1;
  endtask

  // Releases the request and lets the last delay and windows run out
  task automatic drain();
    ctl_req_i = 1'b0;
    while (!ctl_rdy_o) @(negedge clock);
    repeat (`DDR_CWL + `BURST_CYCLES + 4) @(negedge clock);
  endtask

  initial begin
    void'($urandom(32'h7ab1_a191));
    reset        = 1'b1;
    ddr_cke_i    = 1'b0;
    ctl_req_i    = 1'b0;
    ctl_cmd_i    = '{cmd: CMD_NOP, bank: '0, addr: '0};
    mem_wbeat_i  = '0;
    mem_rready_i = 1'b1;
    dfi_rvalid_i = 1'b0;
    dfi_rdata_i  = '0;
    repeat (16) @(negedge clock);
    reset = 1'b0;
    // Clock enable still low, so the layer must stay quiet
    repeat (3) @(negedge clock);
    ddr_cke_i = 1'b1;

    // Power-up sequence with the long ZQ calibration
    send(CMD_MRS, 1'b0);
    send(CMD_MRS, 1'b0);
    send(CMD_ZQCL, 1'b0);
    send(CMD_PRE, 1'b0);
    send(CMD_REF, 1'b0);
    send(CMD_ACT, 1'b0);
    drain();

    // Back-to-back writes and reads with every turnaround
    send(CMD_ACT, 1'b0);
    send(CMD_WR, 1'b0);
    send(CMD_WR, 1'b0);
    send(CMD_RD, 1'b0);
    send(CMD_RD, 1'b0);
    send(CMD_WR, 1'b0);
    send(CMD_WR, 1'b1);
    // Auto-precharge left the memory idle
    send(CMD_ACT, 1'b0);
    send(CMD_RD, 1'b1);
    drain();

    // Clock enable drops during the write to read wait
    // while the write window is open and the read is still in flight
    send(CMD_ACT, 1'b0);
    send(CMD_WR, 1'b0);
    send(CMD_WR, 1'b0);
    send(CMD_RD, 1'b0);
    ctl_req_i = 1'b0;
    repeat (1) @(negedge clock);
    ddr_cke_i = 1'b0;
    repeat (4) @(negedge clock);
    ddr_cke_i = 1'b1;
    send(CMD_REF, 1'b0);
    send(CMD_ACT, 1'b0);
    send(CMD_RD, 1'b0);
    drain();

    $display("Run finished: %0d commands sent, %0d errors", sent_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/ddr3_cmd_pkg.sv
hdl/ddr3_data_pkg.sv
hdl/ddr3_delay_timer.sv
hdl/ddr3_burst_path.sv
hdl/ddr3_cmd_fsm.sv
hdl/ddr3_ddl_top.sv
verif/ddr3_ddl_tb.sv

/* Makefile */
TOP = ddr3_ddl_tb

.PHONY: all sim lint clean

all: sim

obj_dir/V$(TOP): all.f hdl/ddr3_params.svh $(wildcard hdl/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
